/* source/aluPkg.sv */
// ALU opcodes and flags

package aluPkg;

	// opcode numbering follows the ALU instruction encoding
	typedef enum logic [4:0] {
		opMov    = 5'd0,
		opAdd    = 5'd1,
		opAdc    = 5'd2,
		opSub    = 5'd3,
		opSbb    = 5'd4,
		opAnd    = 5'd5,
		opOr     = 5'd6,
		opXor    = 5'd7,
		opMul    = 5'd8,	// signed, low half
		opMulu   = 5'd9,	// signed, high half
		opRrn    = 5'd10,
		opRln    = 5'd11,
		opCmp    = 5'd12,
		opTest   = 5'd13,
		opUmulu  = 5'd14,	// unsigned, high half
		opBswap  = 5'd15,
		opAsr    = 5'd16,
		opLsr    = 5'd17,
		opLsl    = 5'd18,
		opRolc   = 5'd19,
		opRorc   = 5'd20,
		opRol    = 5'd21,
		opRor    = 5'd22,
		opClc    = 5'd23,
		opStc    = 5'd24,
		opClz    = 5'd25,
		opStz    = 5'd26,
		opCls    = 5'd27,
		opSts    = 5'd28,
		opStf    = 5'd29,	// store flags
		opRsf    = 5'd30,	// restore flags
		opNop    = 5'd31
	} aluOpT;

	typedef struct packed {
		logic V;	// signed overflow
		logic S;	// sign
		logic C;	// carry or borrow
		logic Z;	// zero, bit 0
	} flagsT;

endpackage

/* source/execPkg.sv */
// Execute stage control definitions

package execPkg;

	// register number width, 16 registers
	localparam int REG_BITS = 4;

	typedef enum logic [1:0] {
		stIdle     = 2'd0,	// accepting instructions
		stMulWait  = 2'd1,	// multiplier running
		stMulIssue = 2'd2	// product to the ALU
	} ctrlStateT;

endpackage

/* source/execControl.sv */
// Execute stage control
`timescale 1ns/1ns

module execControl (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic                          instrValid,
	input  aluPkg::aluOpT                 opcode,
	input  logic [execPkg::REG_BITS-1:0]  rd,
	input  logic                          mulDone,
	output logic                          ready,
	output logic                          aluIssue,
	output aluPkg::aluOpT                 aluOpSel,
	output logic                          mulStart,
	output logic                          mulSigned,
	output logic                          regWe,
	output logic [execPkg::REG_BITS-1:0]  wbAddr
);
	import aluPkg::*;
	import execPkg::*;

	ctrlStateT state;
	ctrlStateT stateNext;
	aluOpT heldOp;	// multiply waiting for its product
	logic [REG_BITS-1:0] heldRd;
	logic accept;
	logic newIsMul;

	function automatic logic isMulOp(input aluOpT op);
		return (op == opMul) || (op == opMulu) || (op == opUmulu);
	endfunction

	// compare, test and the flag-only operations leave the registers alone
	function automatic logic writesReg(input aluOpT op);
		logic noWrite;
		noWrite = op inside {opCmp, opTest, opClc, opStc, opClz, opStz,
			opCls, opSts, opRsf, opNop};
		return !noWrite;
	endfunction

	assign ready = (state == stIdle);
	assign accept = instrValid && ready;
	assign newIsMul = isMulOp(opcode);
	assign mulStart = accept && newIsMul;
	assign mulSigned = (opcode != opUmulu);	// mul and mulu are signed
	assign aluIssue = (accept && !newIsMul) || (state == stMulIssue);
	assign aluOpSel = (state == stMulIssue) ? heldOp : opcode;

	always_comb begin
		stateNext = state;
		case (state)
			stIdle: begin
				if (mulStart)
					stateNext = stMulWait;
			end
			stMulWait: begin
				if (mulDone)
					stateNext = stMulIssue;
			end
			stMulIssue: stateNext = stIdle;	// single issue cycle
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= stIdle;
			regWe <= 1'b0;
		end else begin
			state <= stateNext;
			regWe <= aluIssue && writesReg(aluOpSel);	// write one cycle after issue
		end
	end

	always_ff @(posedge CLK) begin
		if (mulStart) begin
			heldOp <= opcode;
			heldRd <= rd;
		end
		if (aluIssue)
			wbAddr <= (state == stMulIssue) ? heldRd : rd;
	end

endmodule

/* source/cpuAlu.sv */
// ALU with flag registers
`timescale 1ns/1ns

module cpuAlu #(
	parameter int BITS = 16
) (
	input  logic              CLK,
	input  logic              RSTb,
	input  logic [BITS-1:0]   A,
	input  logic [BITS-1:0]   B,
	input  aluPkg::aluOpT     aluOpSel,
	input  logic              aluIssue,
	input  logic [2*BITS-1:0] product,
	input  logic              flagLoad,
	input  aluPkg::flagsT     flagIn,
	output logic [BITS-1:0]   aluOut,
	output aluPkg::flagsT     flags
);
	import aluPkg::*;

	flagsT flagReg;
	flagsT flagNext;
	logic [BITS-1:0] out;
	logic [BITS-1:0] outReg;

	// one bit wider to keep the carry or borrow
	logic [BITS:0] addOp;
	logic [BITS:0] adcOp;
	logic [BITS:0] subOp;
	logic [BITS:0] sbbOp;

	logic [BITS-1:0] andOp;
	logic [BITS-1:0] orOp;
	logic [BITS-1:0] xorOp;
	logic [BITS-1:0] asrOp;
	logic [BITS-1:0] lsrOp;
	logic [BITS-1:0] lslOp;
	logic [BITS-1:0] rolcOp;
	logic [BITS-1:0] rorcOp;
	logic [BITS-1:0] rolOp;
	logic [BITS-1:0] rorOp;
	logic [BITS-1:0] rlnOp;
	logic [BITS-1:0] rrnOp;
	logic [BITS-1:0] bswapOp;
	logic [BITS-1:0] prodLo;
	logic [BITS-1:0] prodHi;

	assign addOp = {1'b0, A} + {1'b0, B};
	assign adcOp = {1'b0, A} + {1'b0, B} + {{BITS{1'b0}}, flagReg.C};
	assign subOp = {1'b0, A} - {1'b0, B};
	assign sbbOp = {1'b0, A} - {1'b0, B} - {{BITS{1'b0}}, flagReg.C};

	assign andOp = A & B;
	assign orOp = A | B;
	assign xorOp = A ^ B;

	// single-operand ops work on the source
	assign asrOp = {B[BITS-1], B[BITS-1:1]};
	assign lsrOp = {1'b0, B[BITS-1:1]};
	assign lslOp = {B[BITS-2:0], 1'b0};
	assign rolcOp = {B[BITS-2:0], flagReg.C};
	assign rorcOp = {flagReg.C, B[BITS-1:1]};
	assign rolOp = {B[BITS-2:0], B[BITS-1]};
	assign rorOp = {B[0], B[BITS-1:1]};
	assign rlnOp = {B[BITS-5:0], B[BITS-1:BITS-4]};
	assign rrnOp = {B[3:0], B[BITS-1:4]};
	assign bswapOp = {B[7:0], B[BITS-1:8]};

	assign prodLo = product[BITS-1:0];
	assign prodHi = product[2*BITS-1:BITS];

	assign aluOut = outReg;
	assign flags = flagReg;

	always_comb begin
		flagNext = flagReg;	// untouched flags keep their value
		out = '0;
		case (aluOpSel)
			opMov: out = B;
			opAdd: begin
				out = addOp[BITS-1:0];
				flagNext.C = addOp[BITS];
				flagNext.V = !(A[BITS-1] ^ B[BITS-1]) & (B[BITS-1] ^ addOp[BITS-1]);
			end
			opAdc: begin
				out = adcOp[BITS-1:0];
				flagNext.C = adcOp[BITS];
				flagNext.V = !(A[BITS-1] ^ B[BITS-1]) & (B[BITS-1] ^ adcOp[BITS-1]);
			end
			opSub, opCmp: begin
				out = (aluOpSel == opCmp) ? A : subOp[BITS-1:0];
				flagNext.C = subOp[BITS];	// borrow
				flagNext.V = (A[BITS-1] ^ B[BITS-1]) & !(B[BITS-1] ^ subOp[BITS-1]);
			end
			opSbb: begin
				out = sbbOp[BITS-1:0];
				flagNext.C = sbbOp[BITS];
				flagNext.V = (A[BITS-1] ^ B[BITS-1]) & !(B[BITS-1] ^ sbbOp[BITS-1]);
			end
			opAnd: out = andOp;
			opOr: out = orOp;
			opXor: out = xorOp;
			opMul: out = prodLo;
			opMulu, opUmulu: out = prodHi;
			opRrn: out = rrnOp;
			opRln: out = rlnOp;
			opTest: out = A;
			opBswap: out = bswapOp;
			opAsr: out = asrOp;
			opLsr: out = lsrOp;
			opLsl: out = lslOp;
			opRolc: begin
				out = rolcOp;
				flagNext.C = B[BITS-1];	// bit shifted out
			end
			opRorc: begin
				out = rorcOp;
				flagNext.C = B[0];
			end
			opRol: out = rolOp;
			opRor: out = rorOp;
			opClc: flagNext.C = 1'b0;
			opStc: flagNext.C = 1'b1;
			opClz: flagNext.Z = 1'b0;
			opStz: flagNext.Z = 1'b1;
			opCls: flagNext.S = 1'b0;
			opSts: flagNext.S = 1'b1;
			opStf: out = {{(BITS-4){1'b0}}, flagReg};
			opRsf: flagNext = flagsT'(B[3:0]);
			default: ;	// nop
		endcase

		// Z and S follow the result for arithmetic, logic and multiply ops
		if (aluOpSel inside {opAdd, opAdc, opSub, opSbb, opCmp, opAnd, opOr,
				opXor, opMul, opMulu, opUmulu}) begin
			flagNext.Z = (aluOpSel == opCmp) ? (subOp[BITS-1:0] == '0) : (out == '0);
			flagNext.S = (aluOpSel == opCmp) ? subOp[BITS-1] : out[BITS-1];
		end
		if (aluOpSel inside {opAnd, opOr, opXor, opMul, opMulu, opUmulu})
			flagNext.C = 1'b0;
		if (aluOpSel == opTest)
			flagNext.Z = (andOp == '0);	// test sets only Z from the and
		if (aluOpSel inside {opAsr, opLsr, opLsl})
			flagNext.Z = (out == '0);	// shifts touch only Z
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			flagReg <= '0;
			outReg <= '0;
		end else begin
			if (flagLoad)
				flagReg <= flagIn;	// external load wins
			else if (aluIssue)
				flagReg <= flagNext;
			if (aluIssue)
				outReg <= out;
		end
	end

endmodule

/* source/seqMultiplier.sv */
// Iterative shift-add multiplier
`timescale 1ns/1ns

module seqMultiplier #(
	parameter int BITS = 16
) (
	input  logic              CLK,
	input  logic              RSTb,
	input  logic              mulStart,
	input  logic              mulSigned,
	input  logic [BITS-1:0]   A,
	input  logic [BITS-1:0]   B,
	output logic              mulDone,
	output logic [2*BITS-1:0] product
);
	localparam int CNT_BITS = $clog2(BITS + 1);

	logic [CNT_BITS-1:0] count;	// steps left, zero when idle
	logic [2*BITS-1:0] mcand;
	logic [BITS-1:0] mplier;
	logic negate;
	logic [BITS-1:0] magA;
	logic [BITS-1:0] magB;
	logic [2*BITS-1:0] partial;

	// multiply magnitudes, fix the sign at the last step
	assign magA = (mulSigned && A[BITS-1]) ? -A : A;
	assign magB = (mulSigned && B[BITS-1]) ? -B : B;
	assign partial = product + (mplier[0] ? mcand : '0);

	always_ff @(posedge CLK) begin
		if (mulStart) begin
			mcand <= {{BITS{1'b0}}, magA};
			mplier <= magB;
			negate <= mulSigned && (A[BITS-1] ^ B[BITS-1]);
			product <= '0;
		end else if (count != '0) begin
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
			product <= (count == CNT_BITS'(1) && negate) ? -partial : partial;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			count <= '0;
			mulDone <= 1'b0;
		end else begin
			mulDone <= 1'b0;
			if (mulStart) begin
				count <= CNT_BITS'(BITS);
			end else if (count != '0) begin
				count <= count - 1'b1;
				mulDone <= (count == CNT_BITS'(1));	// product valid next cycle
			end
		end
	end

endmodule

/* source/regFile.sv */
// Register file with bypass
`timescale 1ns/1ns

module regFile #(
	parameter int BITS = 16
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic [execPkg::REG_BITS-1:0] rdA,
	input  logic [execPkg::REG_BITS-1:0] rdB,
	input  logic                         regWe,
	input  logic [execPkg::REG_BITS-1:0] wbAddr,
	input  logic [BITS-1:0]              wbData,
	input  logic [execPkg::REG_BITS-1:0] dbgAddr,
	output logic [BITS-1:0]              dataA,
	output logic [BITS-1:0]              dataB,
	output logic [BITS-1:0]              dbgData
);
	import execPkg::*;

	logic [BITS-1:0] regs [2**REG_BITS];

	// same-cycle write goes straight to the read ports
	assign dataA = (regWe && wbAddr == rdA) ? wbData : regs[rdA];
	assign dataB = (regWe && wbAddr == rdB) ? wbData : regs[rdB];
	assign dbgData = regs[dbgAddr];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 2**REG_BITS; i++)
				regs[i] <= '0;
		end else if (regWe) begin
			regs[wbAddr] <= wbData;
		end
	end

endmodule

/* source/aluExecTop.sv */
// Execute stage top level
`timescale 1ns/1ns

module aluExecTop #(
	parameter int BITS = 16
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic                         instrValid,
	input  aluPkg::aluOpT                opcode,
	input  logic [execPkg::REG_BITS-1:0] rd,
	input  logic [execPkg::REG_BITS-1:0] rs,
	input  logic [BITS-1:0]              imm,
	input  logic                         useImm,
	input  logic                         flagLoad,
	input  aluPkg::flagsT                flagIn,
	input  logic [execPkg::REG_BITS-1:0] dbgAddr,
	output logic                         ready,
	output aluPkg::flagsT                flags,
	output logic [BITS-1:0]              dbgData
);
	import aluPkg::*;
	import execPkg::*;

	logic [BITS-1:0] dataA;
	logic [BITS-1:0] dataB;
	logic [BITS-1:0] opB;	// register or immediate
	logic [BITS-1:0] aluOut;
	logic [2*BITS-1:0] product;
	logic aluIssue;
	aluOpT aluOpSel;
	logic mulStart;
	logic mulSigned;
	logic mulDone;
	logic regWe;
	logic [REG_BITS-1:0] wbAddr;

	assign opB = useImm ? imm : dataB;

	execControl i_execControl (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.instrValid (instrValid),
		.opcode     (opcode),
		.rd         (rd),
		.mulDone    (mulDone),
		.ready      (ready),
		.aluIssue   (aluIssue),
		.aluOpSel   (aluOpSel),
		.mulStart   (mulStart),
		.mulSigned  (mulSigned),
		.regWe      (regWe),
		.wbAddr     (wbAddr)
	);

	cpuAlu #(.BITS(BITS)) i_cpuAlu (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.A        (dataA),
		.B        (opB),
		.aluOpSel (aluOpSel),
		.aluIssue (aluIssue),
		.product  (product),
		.flagLoad (flagLoad),
		.flagIn   (flagIn),
		.aluOut   (aluOut),
		.flags    (flags)
	);

	seqMultiplier #(.BITS(BITS)) i_seqMultiplier (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.mulStart  (mulStart),
		.mulSigned (mulSigned),
		.A         (dataA),
		.B         (opB),
		.mulDone   (mulDone),
		.product   (product)
	);

	regFile #(.BITS(BITS)) i_regFile (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.rdA     (rd),	// destination is also operand A
		.rdB     (rs),
		.regWe   (regWe),
		.wbAddr  (wbAddr),
		.wbData  (aluOut),
		.dbgAddr (dbgAddr),
		.dataA   (dataA),
		.dataB   (dataB),
		.dbgData (dbgData)
	);

endmodule

/* dv/aluExec_sva.sv */
// Execute control assertions
`timescale 1ns/1ns

module aluExecSva (
	input logic                CLK,
	input logic                RSTb,
	input execPkg::ctrlStateT  state,
	input logic                aluIssue,
	input aluPkg::aluOpT       aluOpSel,
	input logic                mulDone,
	input logic                regWe
);
	import aluPkg::*;
	import execPkg::*;

	logic writing;	// issued op ends in a register
	assign writing = aluIssue && !(aluOpSel inside {opCmp, opTest, opClc, opStc, opClz,
		opStz, opCls, opSts, opRsf, opNop});

	noIssueInWait: assert property (@(posedge CLK) disable iff (!RSTb)
		state == stMulWait |-> !aluIssue)
		else $error("aluIssue high while the multiplier runs");

	wbAfterIssue: assert property (@(posedge CLK) disable iff (!RSTb)
		writing |=> regWe)
		else $error("regWe missing one cycle after issue");

	noStrayWb: assert property (@(posedge CLK) disable iff (!RSTb)
		!writing |=> !regWe)
		else $error("regWe without a writing issue");

	issueAfterDone: assert property (@(posedge CLK) disable iff (!RSTb)
		mulDone |=> aluIssue)
		else $error("no issue in the cycle after mulDone");

endmodule

bind execControl aluExecSva i_aluExecSva (
	.CLK      (CLK),
	.RSTb     (RSTb),
	.state    (state),
	.aluIssue (aluIssue),
	.aluOpSel (aluOpSel),
	.mulDone  (mulDone),
	.regWe    (regWe)
);

/* dv/aluExecTb.sv */
// Execute stage testbench
`timescale 1ns/1ns

module aluExecTb;
	import aluPkg::*;
	import execPkg::*;

	localparam int BITS = 16;
	localparam int READY_TIMEOUT = 100;	// cycles

	typedef struct packed {
		aluOpT               op;
		logic [REG_BITS-1:0] dst;
		logic [REG_BITS-1:0] src;
		logic [BITS-1:0]     im;
		logic                sel;
		logic [BITS-1:0]     expVal;
		flagsT               expFlags;
	} entryT;

	logic CLK;
	logic RSTb;
	logic instrValid;
	aluOpT opcode;
	logic [REG_BITS-1:0] rd;
	logic [REG_BITS-1:0] rs;
	logic [BITS-1:0] imm;
	logic useImm;
	logic flagLoad;
	flagsT flagIn;
	logic [REG_BITS-1:0] dbgAddr;
	logic ready;
	flagsT flags;
	logic [BITS-1:0] dbgData;

	entryT tbl[$];
	logic [15:0] lfsrState;

	aluExecTop #(.BITS(BITS)) i_aluExecTop (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.instrValid (instrValid),
		.opcode     (opcode),
		.rd         (rd),
		.rs         (rs),
		.imm        (imm),
		.useImm     (useImm),
		.flagLoad   (flagLoad),
		.flagIn     (flagIn),
		.dbgAddr    (dbgAddr),
		.ready      (ready),
		.flags      (flags),
		.dbgData    (dbgData)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 16'hB400;
		return outBit;
	endfunction

	function automatic logic [BITS-1:0] randWord();
		logic [BITS-1:0] w;
		for (int i = 0; i < BITS; i++)
			w[i] = lfsrBit();
		return w;
	endfunction

	task automatic stopRun();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkWord(input logic [BITS-1:0] got, input logic [BITS-1:0] exp,
			input string name);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlags(input flagsT got, input flagsT exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %b expected %b (VSCZ)", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic waitReady();
		int cycles;
		cycles = 0;
		while (!ready) begin
			if (cycles == READY_TIMEOUT) begin
				$display("timeout at %0t ns: ready stayed low after a multiply", $time);
				stopRun();
			end
			@(posedge CLK);
			#1;
			cycles++;
		end
	endtask

	// issue one instruction and wait for its write-back
	task automatic runInstr(input aluOpT op, input logic [REG_BITS-1:0] dst,
			input logic [REG_BITS-1:0] src, input logic [BITS-1:0] im, input logic sel);
		waitReady();
		opcode = op;
		rd = dst;
		rs = src;
		imm = im;
		useImm = sel;
		dbgAddr = dst;
		instrValid = 1'b1;
		@(posedge CLK);
		#1;
		instrValid = 1'b0;
		waitReady();
		repeat (2) @(posedge CLK);
		#1;
	endtask

	// op, rd, rs, imm, useImm, expected rd, expected VSCZ
	task automatic fillTable();
		tbl.push_back({opMov, 4'd1, 4'd0, 16'h7FFF, 1'b1, 16'h7FFF, 4'h0});
		tbl.push_back({opAdd, 4'd1, 4'd0, 16'h0001, 1'b1, 16'h8000, 4'hC});	// overflow
		tbl.push_back({opMov, 4'd2, 4'd0, 16'hFFFF, 1'b1, 16'hFFFF, 4'hC});
		tbl.push_back({opAdd, 4'd2, 4'd0, 16'h0001, 1'b1, 16'h0000, 4'h3});	// carry out, zero
		tbl.push_back({opAdc, 4'd2, 4'd0, 16'h0005, 1'b1, 16'h0006, 4'h0});
		tbl.push_back({opSub, 4'd2, 4'd0, 16'h0007, 1'b1, 16'hFFFF, 4'h6});	// borrow
		tbl.push_back({opSbb, 4'd2, 4'd0, 16'h0001, 1'b1, 16'hFFFD, 4'h4});
		tbl.push_back({opCmp, 4'd2, 4'd0, 16'hFFFD, 1'b1, 16'hFFFD, 4'h1});	// rd untouched
		tbl.push_back({opMulu, 4'd2, 4'd0, 16'h0007, 1'b1, 16'hFFFF, 4'h4});	// -3 * 7
		tbl.push_back({opUmulu, 4'd2, 4'd0, 16'hFFFF, 1'b1, 16'hFFFE, 4'h4});
		tbl.push_back({opMul, 4'd2, 4'd0, 16'h0007, 1'b1, 16'hFFF2, 4'h4});	// -2 * 7
		tbl.push_back({opMov, 4'd3, 4'd0, 16'h0F0F, 1'b1, 16'h0F0F, 4'h4});
		tbl.push_back({opAnd, 4'd3, 4'd0, 16'h00FF, 1'b1, 16'h000F, 4'h0});
		tbl.push_back({opOr, 4'd3, 4'd0, 16'h8000, 1'b1, 16'h800F, 4'h4});
		tbl.push_back({opXor, 4'd3, 4'd0, 16'h800F, 1'b1, 16'h0000, 4'h1});
		tbl.push_back({opTest, 4'd1, 4'd0, 16'h8000, 1'b1, 16'h8000, 4'h0});
		tbl.push_back({opStc, 4'd1, 4'd0, 16'h0000, 1'b1, 16'h8000, 4'h2});	// r1 kept
		tbl.push_back({opAsr, 4'd4, 4'd1, 16'h0000, 1'b0, 16'hC000, 4'h2});	// source r1
		tbl.push_back({opRolc, 4'd5, 4'd0, 16'h8001, 1'b1, 16'h0003, 4'h2});
		tbl.push_back({opRorc, 4'd5, 4'd0, 16'h0002, 1'b1, 16'h8001, 4'h0});
		tbl.push_back({opLsl, 4'd6, 4'd0, 16'h8000, 1'b1, 16'h0000, 4'h1});
		tbl.push_back({opLsr, 4'd6, 4'd0, 16'h8000, 1'b1, 16'h4000, 4'h0});
		tbl.push_back({opRol, 4'd7, 4'd0, 16'h8001, 1'b1, 16'h0003, 4'h0});
		tbl.push_back({opRor, 4'd7, 4'd0, 16'h0003, 1'b1, 16'h8001, 4'h0});
		tbl.push_back({opRln, 4'd8, 4'd0, 16'h1234, 1'b1, 16'h2341, 4'h0});
		tbl.push_back({opRrn, 4'd8, 4'd0, 16'h1234, 1'b1, 16'h4123, 4'h0});
		tbl.push_back({opBswap, 4'd8, 4'd0, 16'h1234, 1'b1, 16'h3412, 4'h0});
		tbl.push_back({opStz, 4'd8, 4'd0, 16'h0000, 1'b1, 16'h3412, 4'h1});
		tbl.push_back({opStc, 4'd4, 4'd0, 16'h0000, 1'b1, 16'hC000, 4'h3});
		tbl.push_back({opSts, 4'd5, 4'd0, 16'h0000, 1'b1, 16'h8001, 4'h7});
		tbl.push_back({opStf, 4'd12, 4'd0, 16'h0000, 1'b1, 16'h0007, 4'h7});
		tbl.push_back({opClz, 4'd6, 4'd0, 16'h0000, 1'b1, 16'h4000, 4'h6});
		tbl.push_back({opCls, 4'd7, 4'd0, 16'h0000, 1'b1, 16'h8001, 4'h2});
		tbl.push_back({opClc, 4'd8, 4'd0, 16'h0000, 1'b1, 16'h3412, 4'h0});
		tbl.push_back({opRsf, 4'd12, 4'd0, 16'h000A, 1'b1, 16'h0007, 4'hA});
		tbl.push_back({opMov, 4'd9, 4'd0, 16'h8000, 1'b1, 16'h8000, 4'hA});
		tbl.push_back({opSbb, 4'd9, 4'd0, 16'h0000, 1'b1, 16'h7FFF, 4'h8});	// borrow overflows
	endtask

	initial begin
		entryT e;
		logic [BITS-1:0] a;
		logic [BITS-1:0] b;
		logic [BITS-1:0] chainVal;
		logic [BITS:0] sum;
		flagsT ef;

		RSTb = 1'b0;
		instrValid = 1'b0;
		opcode = opNop;
		rd = '0;
		rs = '0;
		imm = '0;
		useImm = 1'b0;
		flagLoad = 1'b0;
		flagIn = '0;
		dbgAddr = 4'd7;
		lfsrState = 16'd49;
		fillTable();
		repeat (2) @(posedge CLK);
		#1;
		RSTb = 1'b1;

		checkFlags(flags, 4'h0, "flags after reset");
		checkWord(dbgData, '0, "dbgData (r7 after reset)");
		if (!ready) begin
			$display("ready is low after reset");
			stopRun();
		end

		foreach (tbl[i]) begin
			e = tbl[i];
			runInstr(e.op, e.dst, e.src, e.im, e.sel);
			checkWord(dbgData, e.expVal, $sformatf("dbgData (r%0d, entry %0d)", e.dst, i));
			checkFlags(flags, e.expFlags, $sformatf("flags (entry %0d)", i));
		end

		// random adds checked against the 17-bit sum
		for (int k = 0; k < 6; k++) begin
			a = randWord();
			b = randWord();
			runInstr(opMov, 4'd13, 4'd0, a, 1'b1);
			runInstr(opAdd, 4'd13, 4'd0, b, 1'b1);
			sum = {1'b0, a} + {1'b0, b};
			ef.C = sum[BITS];
			ef.Z = (sum[BITS-1:0] == '0);
			ef.S = sum[BITS-1];
			ef.V = (a[BITS-1] == b[BITS-1]) && (sum[BITS-1] != a[BITS-1]);
			checkWord(dbgData, sum[BITS-1:0], $sformatf("dbgData (r13, random add %0d)", k));
			checkFlags(flags, ef, $sformatf("flags (random add %0d)", k));
		end

		// dependent adds on consecutive cycles and the same chain serially
		runInstr(opMov, 4'd14, 4'd0, 16'd1, 1'b1);
		runInstr(opMov, 4'd15, 4'd0, 16'd1, 1'b1);
		for (int i = 0; i < 4; i++) begin
			if (!ready) begin
				$display("ready dropped during the back-to-back add chain");
				stopRun();
			end
			opcode = opAdd;
			rd = 4'd14;
			imm = BITS'(3 + 2 * i);
			useImm = 1'b1;
			instrValid = 1'b1;
			@(posedge CLK);
			#1;
		end
		instrValid = 1'b0;
		repeat (2) @(posedge CLK);
		#1;
		for (int i = 0; i < 4; i++)
			runInstr(opAdd, 4'd15, 4'd0, BITS'(3 + 2 * i), 1'b1);
		dbgAddr = 4'd14;
		@(posedge CLK);
		#1;
		chainVal = dbgData;
		checkWord(chainVal, 16'h0019, "dbgData (r14, back-to-back chain)");
		dbgAddr = 4'd15;
		@(posedge CLK);
		#1;
		checkWord(dbgData, chainVal, "dbgData (r15, serial chain)");
		checkFlags(flags, 4'h0, "flags after add chain");

		// external load beats a set-carry issued in the same cycle
		opcode = opStc;
		rd = 4'd0;
		flagIn = 4'h9;
		flagLoad = 1'b1;
		instrValid = 1'b1;
		@(posedge CLK);
		#1;
		instrValid = 1'b0;
		flagLoad = 1'b0;
		checkFlags(flags, 4'h9, "flags (flagLoad with stc)");

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* sim.f */
source/aluPkg.sv
source/execPkg.sv
source/execControl.sv
source/cpuAlu.sv
source/seqMultiplier.sv
source/regFile.sv
source/aluExecTop.sv
dv/aluExec_sva.sv
dv/aluExecTb.sv
